// File: source/hss_link_pkg.sv
// Serial link shared definitions
package hss_link_pkg;

  // K-character codes
  // Comma marks lane 3 of a handshake word
  localparam logic [7:0] KCH_COMMA = 8'hbc;
  // Handshake marker in lane 2
  localparam logic [7:0] KCH_HANDSHAKE = 8'h7c;
  // Clock correction, repeated in every lane
  localparam logic [7:0] KCH_CLKC = 8'h1c;

  // K flag patterns of the two control words
  localparam logic [3:0] HS_K_FLAGS = 4'b1100;
  localparam logic [3:0] CLKC_K_FLAGS = 4'b1111;

  // Version byte sent in lane 0 of every handshake word
  localparam logic [7:0] PROTOCOL_VERSION = 8'h01;

  // Clock correction timer
  // Counts 0 to CLKC_INTERVAL so one word goes out every 251 cycles
  localparam int CLKC_CNT_W = 8;
  localparam logic [CLKC_CNT_W-1:0] CLKC_INTERVAL = 8'd250;

  // Sync errors tolerated while the link is up before a restart
  localparam int SYNC_ERR_CNT_W = 3;
  localparam logic [SYNC_ERR_CNT_W-1:0] SYNC_ERR_LIMIT = 3'd4;

  // Handshake FSM encodings
  localparam logic [1:0] HS_ST_PHASE0 = 2'd0;
  localparam logic [1:0] HS_ST_PHASE1 = 2'd1;
  localparam logic [1:0] HS_ST_COMPLETE = 2'd2;

  // Byte fields of a handshake word, lane 3 first
  typedef struct packed {
    logic [7:0] comma;
    logic [7:0] hs_kch;
    // Only bit 0 carries the phase
    logic [7:0] phase;
    logic [7:0] version;
  } hss_hs_fields_t;

  // One received word seen as plain data or as a handshake word
  typedef union packed {
    logic [31:0] data;
    hss_hs_fields_t hs;
  } hss_word_t;

endpackage

// File: source/hss_link_tx_control.sv
// Serial link transmit control
`timescale 1ns/1ps

module hss_link_tx_control (
  input  logic        clk_in,
  input  logic        reset_in,
  // Handshake status
  input  logic        hs_complete_i,
  input  logic        hs_phase_i,
  // User word
  input  logic [31:0] tx_data_i,
  input  logic [3:0]  tx_charisk_i,
  // Transceiver side
  output logic [31:0] hss_txdata_o,
  output logic [3:0]  hss_txcharisk_o,
  // User word is taken in every cycle this is high
  output logic        tx_rdy_o
);

  import hss_link_pkg::*;

  logic [CLKC_CNT_W-1:0] clkc_cnt_q;
  logic                  clkc_due;
  logic                  send_clkc_q;
  logic                  send_hs_q;

  // Free-running clock correction timer
  always_ff @(posedge clk_in or posedge reset_in)
  begin
    if (reset_in)
      clkc_cnt_q <= '0;
    else if (clkc_cnt_q == CLKC_INTERVAL)
      clkc_cnt_q <= '0;
    else
      clkc_cnt_q <= clkc_cnt_q + 1'b1;
  end

  // Due in the cycle the timer sits at zero
  assign clkc_due = (clkc_cnt_q == '0);

  // Send requests lag by one cycle
  // Matches the cycle in which ready was dropped for them
  always_ff @(posedge clk_in or posedge reset_in)
  begin
    if (reset_in)
    begin
      send_clkc_q <= 1'b0;
      // Handshake goes out straight after reset
      send_hs_q <= 1'b1;
    end
    else
    begin
      send_clkc_q <= clkc_due;
      send_hs_q <= !hs_complete_i;
    end
  end

  // Word selection
  // Clock correction wins over the handshake word
  always_ff @(posedge clk_in or posedge reset_in)
  begin
    if (reset_in)
    begin
      hss_txdata_o <= '0;
      hss_txcharisk_o <= '0;
    end
    else if (send_clkc_q)
    begin
      hss_txdata_o <= {4{KCH_CLKC}};
      hss_txcharisk_o <= CLKC_K_FLAGS;
    end
    else if (send_hs_q)
    begin
      hss_txdata_o <= {KCH_COMMA, KCH_HANDSHAKE, {7'b0, hs_phase_i}, PROTOCOL_VERSION};
      hss_txcharisk_o <= HS_K_FLAGS;
    end
    else
    begin
      hss_txdata_o <= tx_data_i;
      hss_txcharisk_o <= tx_charisk_i;
    end
  end

  // Ready only when the link is up and no control word is pending
  always_ff @(posedge clk_in or posedge reset_in)
  begin
    if (reset_in)
      tx_rdy_o <= 1'b0;
    else
      tx_rdy_o <= !clkc_due && hs_complete_i;
  end

endmodule

// File: source/hss_link_rx_control.sv
// Serial link receive control
`timescale 1ns/1ps

module hss_link_rx_control (
  input  logic        clk_in,
  input  logic        reset_in,
  // Transceiver side, arbitrary byte rotation
  input  logic [31:0] hss_rxdata_i,
  input  logic [3:0]  hss_rxcharisk_i,
  // Handshake status
  input  logic        hs_complete_i,
  input  logic        hs_restart_i,
  // User words
  output logic [31:0] rx_data_o,
  output logic [3:0]  rx_charisk_o,
  output logic        rx_vld_o,
  // Decoded handshake word
  output logic        rx_hs_vld_o,
  output logic        rx_hs_phase_o,
  output logic [7:0]  rx_hs_version_o,
  // Comma seen in the wrong lane
  output logic        rx_sync_err_o
);

  import hss_link_pkg::*;

  // Previous raw word
  logic [31:0] cur_data_q;
  logic [3:0]  cur_k_q;

  // Lock state
  logic       aligned_q;
  logic [1:0] lane_q;

  // Comma search on the raw input
  logic       comma_seen;
  logic [1:0] comma_lane;

  // Realigned word and its decode
  hss_word_t  al_word;
  logic [3:0] al_k;
  logic       is_hs;
  logic       is_clkc;

  // Hold the previous raw word
  always_ff @(posedge clk_in)
  begin
    cur_data_q <= hss_rxdata_i;
    cur_k_q <= hss_rxcharisk_i;
  end

  // Find a comma K-char in any lane
  // Highest lane wins if more than one shows up
  always_comb
  begin
    comma_seen = 1'b0;
    comma_lane = 2'd0;
    for (int i = 0; i < 4; i++)
    begin
      if (hss_rxcharisk_i[i] && (hss_rxdata_i[8*i +: 8] == KCH_COMMA))
      begin
        comma_seen = 1'b1;
        comma_lane = 2'(i);
      end
    end
  end

  // Lane lock
  // Any comma moves the lock until the handshake completes
  always_ff @(posedge clk_in or posedge reset_in)
  begin
    if (reset_in)
    begin
      aligned_q <= 1'b0;
      lane_q <= 2'd3;
    end
    else if (hs_restart_i)
      // Drop lock and ignore this cycle's word
      aligned_q <= 1'b0;
    else if (comma_seen && (!aligned_q || !hs_complete_i))
    begin
      aligned_q <= 1'b1;
      lane_q <= comma_lane;
    end
  end

  // Pick four bytes from previous and current raw words
  // Locked lane holds the comma, which becomes lane 3
  always_comb
  begin
    case (lane_q)
      2'd3:
      begin
        al_word.data = cur_data_q;
        al_k = cur_k_q;
      end
      2'd2:
      begin
        al_word.data = {cur_data_q[23:0], hss_rxdata_i[31:24]};
        al_k = {cur_k_q[2:0], hss_rxcharisk_i[3]};
      end
      2'd1:
      begin
        al_word.data = {cur_data_q[15:0], hss_rxdata_i[31:16]};
        al_k = {cur_k_q[1:0], hss_rxcharisk_i[3:2]};
      end
      default:
      begin
        al_word.data = {cur_data_q[7:0], hss_rxdata_i[31:8]};
        al_k = {cur_k_q[0], hss_rxcharisk_i[3:1]};
      end
    endcase
  end

  // Control word recognition
  assign is_hs = (al_k == HS_K_FLAGS) && (al_word.hs.comma == KCH_COMMA)
                 && (al_word.hs.hs_kch == KCH_HANDSHAKE);
  assign is_clkc = (al_k == CLKC_K_FLAGS) && (al_word.data == {4{KCH_CLKC}});

  // Strobes
  // Control words never reach the user side
  // Nothing is passed on in a restart cycle
  always_ff @(posedge clk_in or posedge reset_in)
  begin
    if (reset_in)
    begin
      rx_vld_o <= 1'b0;
      rx_hs_vld_o <= 1'b0;
      rx_sync_err_o <= 1'b0;
    end
    else
    begin
      rx_vld_o <= aligned_q && !hs_restart_i && !is_hs && !is_clkc;
      rx_hs_vld_o <= aligned_q && !hs_restart_i && is_hs;
      // Only a locked and completed link can lose sync
      rx_sync_err_o <= comma_seen && aligned_q && hs_complete_i
                       && (comma_lane != lane_q) && !hs_restart_i;
    end
  end

  // Payload
  always_ff @(posedge clk_in)
  begin
    rx_data_o <= al_word.data;
    rx_charisk_o <= al_k;
    rx_hs_phase_o <= al_word.hs.phase[0];
    rx_hs_version_o <= al_word.hs.version;
  end

endmodule

// File: source/hss_link_handshake.sv
// Serial link handshake controller
`timescale 1ns/1ps

module hss_link_handshake (
  input  logic       clk_in,
  input  logic       reset_in,
  // Decoded handshake words from receive control
  input  logic       rx_hs_vld_i,
  input  logic       rx_hs_phase_i,
  input  logic [7:0] rx_hs_version_i,
  // Misplaced comma pulse
  input  logic       rx_sync_err_i,
  // Status to transmit and receive control
  output logic       hs_complete_o,
  output logic       hs_phase_o,
  output logic       hs_restart_o
);

  import hss_link_pkg::*;

  logic [1:0]                state_q;
  logic [1:0]                state_nxt;
  logic [SYNC_ERR_CNT_W-1:0] err_cnt_q;
  logic                      version_ok;
  logic                      restart_due;

  // Only handshakes from a compatible peer move the FSM
  assign version_ok = rx_hs_vld_i && (rx_hs_version_i == PROTOCOL_VERSION);

  // Error limit reached on an up link
  assign restart_due = (state_q == HS_ST_COMPLETE) && (err_cnt_q == SYNC_ERR_LIMIT);

  // Next state
  always_comb
  begin
    state_nxt = state_q;
    case (state_q)
      HS_ST_PHASE0:
      begin
        // Peer is heard, announce phase 1
        if (version_ok)
          state_nxt = HS_ST_PHASE1;
      end
      HS_ST_PHASE1:
      begin
        // Peer has heard us too
        if (version_ok && rx_hs_phase_i)
          state_nxt = HS_ST_COMPLETE;
        // Wrong version sends us back
        else if (rx_hs_vld_i && !version_ok)
          state_nxt = HS_ST_PHASE0;
      end
      HS_ST_COMPLETE:
      begin
        if (restart_due)
          state_nxt = HS_ST_PHASE0;
      end
      default:
        state_nxt = HS_ST_PHASE0;
    endcase
  end

  always_ff @(posedge clk_in or posedge reset_in)
  begin
    if (reset_in)
      state_q <= HS_ST_PHASE0;
    else
      state_q <= state_nxt;
  end

  // Saturating sync error counter
  // Only runs while the link is up
  always_ff @(posedge clk_in or posedge reset_in)
  begin
    if (reset_in)
      err_cnt_q <= '0;
    else if (hs_restart_o || (state_q != HS_ST_COMPLETE))
      err_cnt_q <= '0;
    else if (rx_sync_err_i && (err_cnt_q != SYNC_ERR_LIMIT))
      err_cnt_q <= err_cnt_q + 1'b1;
  end

  // One-cycle restart pulse
  // State leaves complete on the same edge so it cannot repeat
  always_ff @(posedge clk_in or posedge reset_in)
  begin
    if (reset_in)
      hs_restart_o <= 1'b0;
    else
      hs_restart_o <= restart_due;
  end

  // Status decode
  assign hs_complete_o = (state_q == HS_ST_COMPLETE);
  assign hs_phase_o = (state_q == HS_ST_PHASE1);

endmodule

// File: source/hss_link_top.sv
// Serial link control top level
`timescale 1ns/1ps

module hss_link_top (
  input  logic        clk_in,
  input  logic        reset_in,
  // Transceiver transmit side
  output logic [31:0] hss_txdata_o,
  output logic [3:0]  hss_txcharisk_o,
  // Transceiver receive side
  input  logic [31:0] hss_rxdata_i,
  input  logic [3:0]  hss_rxcharisk_i,
  // User transmit side
  input  logic [31:0] tx_data_i,
  input  logic [3:0]  tx_charisk_i,
  output logic        tx_rdy_o,
  // User receive side
  output logic [31:0] rx_data_o,
  output logic [3:0]  rx_charisk_o,
  output logic        rx_vld_o,
  // Handshake done
  output logic        link_up_o
);

  // Handshake status
  logic       hs_complete;
  logic       hs_phase;
  logic       hs_restart;

  // Receive control reports
  logic       rx_hs_vld;
  logic       rx_hs_phase;
  logic [7:0] rx_hs_version;
  logic       rx_sync_err;

  hss_link_tx_control i_tx_control (
    .clk_in          (clk_in),
    .reset_in        (reset_in),
    .hs_complete_i   (hs_complete),
    .hs_phase_i      (hs_phase),
    .tx_data_i       (tx_data_i),
    .tx_charisk_i    (tx_charisk_i),
    .hss_txdata_o    (hss_txdata_o),
    .hss_txcharisk_o (hss_txcharisk_o),
    .tx_rdy_o        (tx_rdy_o)
  );

  hss_link_rx_control i_rx_control (
    .clk_in          (clk_in),
    .reset_in        (reset_in),
    .hss_rxdata_i    (hss_rxdata_i),
    .hss_rxcharisk_i (hss_rxcharisk_i),
    .hs_complete_i   (hs_complete),
    .hs_restart_i    (hs_restart),
    .rx_data_o       (rx_data_o),
    .rx_charisk_o    (rx_charisk_o),
    .rx_vld_o        (rx_vld_o),
    .rx_hs_vld_o     (rx_hs_vld),
    .rx_hs_phase_o   (rx_hs_phase),
    .rx_hs_version_o (rx_hs_version),
    .rx_sync_err_o   (rx_sync_err)
  );

  hss_link_handshake i_handshake (
    .clk_in          (clk_in),
    .reset_in        (reset_in),
    .rx_hs_vld_i     (rx_hs_vld),
    .rx_hs_phase_i   (rx_hs_phase),
    .rx_hs_version_i (rx_hs_version),
    .rx_sync_err_i   (rx_sync_err),
    .hs_complete_o   (hs_complete),
    .hs_phase_o      (hs_phase),
    .hs_restart_o    (hs_restart)
  );

  // Link is up exactly while the handshake is complete
  assign link_up_o = hs_complete;

endmodule

// File: tb/hss_link_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module hss_link_clock_gen (
  input  logic reset_req_i,
  output logic clk_o,
  output logic reset_o
);

  int rst_cnt;

  // 4 ns period
  initial
  begin
    clk_o = 1'b0;
    forever
      #2 clk_o = ~clk_o;
  end

  // Held at start until three rising edges have passed
  initial
  begin
    reset_o = 1'b1;
    rst_cnt = 0;
  end

  // A request restarts the three-cycle reset
  always @(posedge clk_o)
  begin
    if (reset_req_i)
    begin
      reset_o <= 1'b1;
      rst_cnt <= 0;
    end
    else if (reset_o)
    begin
      if (rst_cnt == 2)
        reset_o <= 1'b0;
      rst_cnt <= rst_cnt + 1;
    end
  end

endmodule

// File: tb/hss_link_asserts.sv
// Link control assertions
`timescale 1ns/1ps

module hss_link_asserts (
  input logic        clk_in,
  input logic        reset_in,
  input logic [3:0]  hss_txcharisk_i,
  input logic        tx_rdy_i,
  input logic [31:0] rx_data_i,
  input logic [3:0]  rx_charisk_i,
  input logic        rx_vld_i,
  input logic        link_up_i
);

  import hss_link_pkg::*;

  // Ready is registered from the link state one cycle earlier
  a_rdy_needs_link: assert property (
    @(posedge clk_in) disable iff (reset_in) tx_rdy_i |-> $past(link_up_i)
  ) else $error("tx_rdy_o high while the link was down");

  // Clock correction words are stripped before the user side
  a_no_clkc_out: assert property (
    @(posedge clk_in) disable iff (reset_in)
    rx_vld_i |-> !((rx_charisk_i == CLKC_K_FLAGS) && (rx_data_i == {4{KCH_CLKC}}))
  ) else $error("clock correction word seen on rx_data_o");

  // No K flags in the first cycle out of reset
  a_tx_k_after_reset: assert property (
    @(posedge clk_in) $fell(reset_in) |-> (hss_txcharisk_i == 4'b0)
  ) else $error("hss_txcharisk_o not zero in the first cycle after reset");

endmodule

// File: tb/hss_link_tb.sv
// Serial link control testbench
`timescale 1ns/1ps

module hss_link_tb;

  import hss_link_pkg::*;

  localparam int LINK_TIMEOUT = 400;
  localparam int WORDS_PER_ROT = 40;

  logic        clk;
  logic        reset;
  logic        reset_req;
  logic [31:0] hss_txdata;
  logic [3:0]  hss_txcharisk;
  logic [31:0] hss_rxdata;
  logic [3:0]  hss_rxcharisk;
  logic [31:0] tx_data;
  logic [3:0]  tx_charisk;
  logic        tx_rdy;
  logic [31:0] rx_data;
  logic [3:0]  rx_charisk;
  logic        rx_vld;
  logic        link_up;

  // Channel controls and one word of history
  logic [1:0]  rot;
  logic        inj_en;
  logic [31:0] inj_data;
  logic [3:0]  inj_k;
  logic [31:0] hist_data;
  logic [3:0]  hist_k;

  integer      seed;
  int          err_cnt;
  // K flags above data
  logic [35:0] exp_q[$];

  hss_link_clock_gen i_clock_gen (
    .reset_req_i (reset_req),
    .clk_o       (clk),
    .reset_o     (reset)
  );

  hss_link_top i_dut (
    .clk_in          (clk),
    .reset_in        (reset),
    .hss_txdata_o    (hss_txdata),
    .hss_txcharisk_o (hss_txcharisk),
    .hss_rxdata_i    (hss_rxdata),
    .hss_rxcharisk_i (hss_rxcharisk),
    .tx_data_i       (tx_data),
    .tx_charisk_i    (tx_charisk),
    .tx_rdy_o        (tx_rdy),
    .rx_data_o       (rx_data),
    .rx_charisk_o    (rx_charisk),
    .rx_vld_o        (rx_vld),
    .link_up_o       (link_up)
  );

  bind hss_link_top hss_link_asserts i_asserts (
    .clk_in          (clk_in),
    .reset_in        (reset_in),
    .hss_txcharisk_i (hss_txcharisk_o),
    .tx_rdy_i        (tx_rdy_o),
    .rx_data_i       (rx_data_o),
    .rx_charisk_i    (rx_charisk_o),
    .rx_vld_i        (rx_vld_o),
    .link_up_i       (link_up_o)
  );

  // Older word on top, shifted down by whole bytes
  function automatic logic [31:0] rotate_bytes(logic [31:0] hi, logic [31:0] lo, logic [1:0] r);
    logic [63:0] both;
    both = {hi, lo} >> (8 * r);
    return both[31:0];
  endfunction

  function automatic logic [3:0] rotate_flags(logic [3:0] hi, logic [3:0] lo, logic [1:0] r);
    logic [7:0] both;
    both = {hi, lo} >> r;
    return both[3:0];
  endfunction

  // Comma, handshake K-char, phase, version
  function automatic logic [31:0] hs_word(logic phase, logic [7:0] ver);
    hss_word_t w;
    w.hs.comma = KCH_COMMA;
    w.hs.hs_kch = KCH_HANDSHAKE;
    w.hs.phase = {7'b0, phase};
    w.hs.version = ver;
    return w.data;
  endfunction

  // Random user word with no comma and no clock correction pattern
  function automatic logic [35:0] make_user_word(logic [31:0] d, logic [3:0] k);
    for (int i = 0; i < 4; i++)
      if (k[i] && (d[8*i +: 8] == KCH_COMMA))
        d[8*i] = ~d[8*i];
    if ((k == CLKC_K_FLAGS) && (d == {4{KCH_CLKC}}))
      d[0] = ~d[0];
    return {k, d};
  endfunction

  // Loopback, or words forced by a test
  always @(negedge clk)
  begin
    if (inj_en)
    begin
      hss_rxdata <= inj_data;
      hss_rxcharisk <= inj_k;
    end
    else
    begin
      hss_rxdata <= rotate_bytes(hist_data, hss_txdata, rot);
      hss_rxcharisk <= rotate_flags(hist_k, hss_txcharisk, rot);
    end
    hist_data <= hss_txdata;
    hist_k <= hss_txcharisk;
  end

  task automatic stop_run();
    err_cnt++;
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic fail_with(string why);
    $display("Error at %0t: %s", $time, why);
    stop_run();
  endtask

  task automatic check_value(string name, logic [35:0] got, logic [35:0] exp);
    if (got !== exp)
    begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic await_reset_release();
    int n;
    n = 0;
    while (reset)
    begin
      @(negedge clk);
      n++;
      if (n > 20)
        fail_with("reset was never released");
    end
  endtask

  task automatic wait_link_level(logic level, int limit);
    int n;
    n = 0;
    while (link_up !== level)
    begin
      @(negedge clk);
      n++;
      if (n > limit)
        fail_with(level ? "link_up_o did not rise in time" : "link_up_o did not drop in time");
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset_req = 1'b1;
    @(negedge clk);
    reset_req = 1'b0;
    await_reset_release();
  endtask

  task automatic verify_reset_state();
    int n;
    n = 0;
    check_value("tx_rdy_o", tx_rdy, 1'b0);
    check_value("rx_vld_o", rx_vld, 1'b0);
    check_value("link_up_o", link_up, 1'b0);
    // Skip the reset value and any clock correction word
    while ((hss_txcharisk == 4'b0) || (hss_txcharisk == CLKC_K_FLAGS))
    begin
      @(negedge clk);
      n++;
      if (n > 10)
        fail_with("no handshake word sent after reset");
    end
    check_value("hss_txcharisk_o", hss_txcharisk, HS_K_FLAGS);
    check_value("hss_txdata_o", hss_txdata, hs_word(1'b0, PROTOCOL_VERSION));
  endtask

  task automatic run_loopback_handshake();
    hss_word_t w;
    logic      saw_phase1;
    int        n;
    saw_phase1 = 1'b0;
    n = 0;
    while (!link_up)
    begin
      w.data = hss_txdata;
      if ((hss_txcharisk == HS_K_FLAGS) && w.hs.phase[0])
        saw_phase1 = 1'b1;
      @(negedge clk);
      n++;
      if (n > LINK_TIMEOUT)
        fail_with("link_up_o did not rise in loopback");
    end
    check_value("hss_txdata_o phase 1 before link up", saw_phase1, 1'b1);
  endtask

  task automatic transfer_rotated_data(logic [1:0] r);
    logic [35:0] exp;
    logic [31:0] rnd_d;
    logic [3:0]  rnd_k;
    int          sent;
    int          recv;
    int          n;
    sent = 0;
    recv = 0;
    n = 0;
    rot <= r;
    apply_reset();
    wait_link_level(1'b1, LINK_TIMEOUT);
    exp_q.delete();
    while (recv < WORDS_PER_ROT)
    begin
      if (rx_vld)
      begin
        if (exp_q.size() == 0)
          fail_with("rx_vld_o raised with no word outstanding");
        exp = exp_q.pop_front();
        check_value("rx_data_o", rx_data, exp[31:0]);
        check_value("rx_charisk_o", rx_charisk, exp[35:32]);
        recv++;
      end
      // Ready high means this word is taken at the next edge
      if (tx_rdy && (sent < WORDS_PER_ROT))
      begin
        rnd_d = $random(seed);
        rnd_k = $random(seed);
        {tx_charisk, tx_data} = make_user_word(rnd_d, rnd_k);
        exp_q.push_back({tx_charisk, tx_data});
        sent++;
      end
      @(negedge clk);
      n++;
      if (n > 4 * WORDS_PER_ROT + 100)
        fail_with("user words were not all received");
    end
  endtask

  task automatic measure_clock_correction();
    int   last;
    int   count;
    logic prev_rdy;
    last = -1;
    count = 0;
    prev_rdy = tx_rdy;
    for (int c = 0; c < 1000; c++)
    begin
      @(negedge clk);
      if ((hss_txcharisk == CLKC_K_FLAGS) && (hss_txdata == {4{KCH_CLKC}}))
      begin
        check_value("tx_rdy_o before clock correction", prev_rdy, 1'b0);
        if (last >= 0)
          check_value("hss_txdata_o clock correction spacing", c - last, 251);
        last = c;
        count++;
      end
      if (rx_vld && (rx_charisk == CLKC_K_FLAGS) && (rx_data == {4{KCH_CLKC}}))
        fail_with("clock correction word reached rx_data_o");
      prev_rdy = tx_rdy;
    end
    check_value("hss_txdata_o clock correction count of 3 or more", count >= 3, 1'b1);
  endtask

  task automatic reject_wrong_version();
    hss_word_t w;
    rot <= 2'd0;
    inj_data <= hs_word(1'b1, PROTOCOL_VERSION ^ 8'hff);
    inj_k <= HS_K_FLAGS;
    inj_en <= 1'b1;
    apply_reset();
    for (int c = 0; c < LINK_TIMEOUT; c++)
    begin
      w.data = hss_txdata;
      check_value("link_up_o", link_up, 1'b0);
      if (hss_txcharisk == HS_K_FLAGS)
        check_value("hss_txdata_o phase", w.hs.phase, 8'h00);
      @(negedge clk);
    end
  endtask

  task automatic recover_from_sync_loss();
    int n;
    n = 0;
    // Own handshakes come back and the link forms
    inj_en <= 1'b0;
    wait_link_level(1'b1, LINK_TIMEOUT);
    // Comma in lane 0 while lane 3 is locked
    inj_data <= {24'h0, KCH_COMMA};
    inj_k <= 4'b0001;
    inj_en <= 1'b1;
    repeat (SYNC_ERR_LIMIT) @(negedge clk);
    inj_en <= 1'b0;
    wait_link_level(1'b0, 20);
    while ((hss_txcharisk != HS_K_FLAGS) || (hss_txdata != hs_word(1'b0, PROTOCOL_VERSION)))
    begin
      @(negedge clk);
      n++;
      if (n > 20)
        fail_with("no phase 0 handshake after the link dropped");
    end
    wait_link_level(1'b1, LINK_TIMEOUT);
  endtask

  initial
  begin
    seed = 32'h9eff2b94;
    err_cnt = 0;
    reset_req = 1'b0;
    tx_data = '0;
    tx_charisk = '0;
    hss_rxdata = '0;
    hss_rxcharisk = '0;
    rot = 2'd0;
    inj_en = 1'b0;
    inj_data = '0;
    inj_k = '0;
    hist_data = '0;
    hist_k = '0;
    @(negedge clk);
    await_reset_release();
    verify_reset_state();
    run_loopback_handshake();
    for (int r = 0; r < 4; r++)
      transfer_rotated_data(2'(r));
    measure_clock_correction();
    reject_wrong_version();
    recover_from_sync_loss();
    if (err_cnt == 0)
    begin
      $display("sim passed");
      $finish;
    end
    else
      stop_run();
  end

endmodule

// File: files.f
source/hss_link_pkg.sv
source/hss_link_tx_control.sv
source/hss_link_rx_control.sv
source/hss_link_handshake.sv
source/hss_link_top.sv
tb/hss_link_clock_gen.sv
tb/hss_link_asserts.sv
tb/hss_link_tb.sv
